// ==== source/l1_cache_params.svh ====
// ====================
// width and geometry macros for the l1 data cache
// one word per line, direct mapped
// ====================
`ifndef L1_CACHE_PARAMS_SVH
`define L1_CACHE_PARAMS_SVH

// byte address
`define ADDR_WID 32

// line width, one word
`define DATA_WID 32

// byte offset inside a line
`define OFFSET_WID 2

// 16 lines
`define INDEX_WID 4

// what is left of the address
`define TAG_WID 26

`endif

// ==== source/mesi_pkg.sv ====
// ====================
// coherence types
// line state, level 2 commands, snoop commands
// ====================
`default_nettype none

package mesi_pkg;

    typedef enum logic [1:0] {
        mesi_invalid   = 2'b00,
        mesi_shared    = 2'b01,
        mesi_exclusive = 2'b10,
        mesi_modified  = 2'b11
    } mesi_t;

    // requests toward level 2
    typedef enum logic [1:0] {
        mem_read      = 2'b00,
        mem_read_excl = 2'b01,
        mem_upgrade   = 2'b10,
        mem_writeback = 2'b11
    } mem_cmd_t;

    typedef enum logic {
        snoop_read  = 1'b0,
        snoop_inval = 1'b1
    } snp_cmd_t;

endpackage

`default_nettype wire

// ==== source/l1_cache_pkg.sv ====
// ====================
// cache types
// address fields, line data, processor FSM states
// ====================
`default_nettype none

`include "l1_cache_params.svh"

package l1_cache_pkg;

    typedef logic [`ADDR_WID-1:0]  addr_t;
    typedef logic [`TAG_WID-1:0]   tag_t;
    typedef logic [`INDEX_WID-1:0] index_t;
    typedef logic [`DATA_WID-1:0]  data_t;

    // processor side controller
    typedef enum logic [2:0] {
        ps_idle      = 3'd0,
        ps_writeback = 3'd1,
        ps_fill      = 3'd2,
        ps_upgrade   = 3'd3,
        // waiting for the level 2 ack to fall
        ps_respond   = 3'd4,
        // cpu_ack high, waiting for cpu_req to fall
        ps_release   = 3'd5
    } proc_state_t;

endpackage

`default_nettype wire

// ==== source/l1_tag_store.sv ====
// ====================
// tag and MESI state array
// processor and snoop lookups, one write port
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_params.svh"

module l1_tag_store (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire l1_cache_pkg::index_t proc_index,
    input  wire l1_cache_pkg::index_t snoop_index,
    input  wire                       wr_en,
    input  wire l1_cache_pkg::index_t wr_index,
    input  wire l1_cache_pkg::tag_t   wr_tag,
    input  wire mesi_pkg::mesi_t      wr_state,
    output l1_cache_pkg::tag_t        proc_tag,
    output mesi_pkg::mesi_t           proc_state,
    output l1_cache_pkg::tag_t        snoop_tag,
    output mesi_pkg::mesi_t           snoop_state
);

    localparam int DEPTH = 1 << `INDEX_WID;

    l1_cache_pkg::tag_t tag_mem   [DEPTH];
    mesi_pkg::mesi_t    state_mem [DEPTH];

    // every line starts invalid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                state_mem[i] <= mesi_pkg::mesi_invalid;
            end
        end else if (wr_en) begin
            state_mem[wr_index] <= wr_state;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
    end

    assign proc_tag    = tag_mem[proc_index];
    assign proc_state  = state_mem[proc_index];
    assign snoop_tag   = tag_mem[snoop_index];
    assign snoop_state = state_mem[snoop_index];

endmodule

`default_nettype wire

// ==== source/l1_data_store.sv ====
// ====================
// line data array
// processor read/write, snoop read only
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_params.svh"

module l1_data_store (
    input  wire                       clk,
    input  wire l1_cache_pkg::index_t proc_index,
    input  wire                       wr_en,
    input  wire l1_cache_pkg::data_t  wr_data,
    input  wire l1_cache_pkg::index_t snoop_index,
    output l1_cache_pkg::data_t       proc_data,
    output l1_cache_pkg::data_t       snoop_data
);

    localparam int DEPTH = 1 << `INDEX_WID;

    l1_cache_pkg::data_t data_mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[proc_index] <= wr_data;
        end
    end

    assign proc_data  = data_mem[proc_index];
    assign snoop_data = data_mem[snoop_index];

endmodule

`default_nettype wire

// ==== source/l1_proc_ctrl.sv ====
// ====================
// processor side controller
// hits, fills, upgrades, victim writeback
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_params.svh"

module l1_proc_ctrl (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cpu_req,
    input  wire                      cpu_we,
    input  wire l1_cache_pkg::addr_t cpu_addr,
    input  wire l1_cache_pkg::data_t cpu_wdata,
    input  wire l1_cache_pkg::tag_t  line_tag,
    input  wire mesi_pkg::mesi_t     line_state,
    input  wire l1_cache_pkg::data_t line_data,
    input  wire                      mem_ack,
    input  wire l1_cache_pkg::data_t mem_rdata,
    input  wire                      mem_shared,
    input  wire                      snoop_busy,
    output logic                     cpu_ack,
    output l1_cache_pkg::data_t      cpu_rdata,
    output logic                     mem_req,
    output mesi_pkg::mem_cmd_t       mem_cmd,
    output l1_cache_pkg::addr_t      mem_addr,
    output l1_cache_pkg::data_t      mem_wdata,
    output logic                     tag_wr_en,
    output mesi_pkg::mesi_t          tag_wr_state,
    output logic                     data_wr_en,
    output l1_cache_pkg::data_t      data_wr_data,
    output logic                     proc_busy
);

    l1_cache_pkg::proc_state_t state;
    l1_cache_pkg::tag_t        cpu_tag;
    l1_cache_pkg::index_t      cpu_index;
    l1_cache_pkg::addr_t       line_addr;
    l1_cache_pkg::addr_t       victim_addr;
    mesi_pkg::mem_cmd_t        fill_cmd;
    logic                      hit;
    logic                      start;
    logic                      mem_done;

    assign cpu_tag     = cpu_addr[`ADDR_WID-1 -: `TAG_WID];
    assign cpu_index   = cpu_addr[`OFFSET_WID +: `INDEX_WID];
    assign line_addr   = {cpu_tag, cpu_index, {`OFFSET_WID{1'b0}}};
    assign victim_addr = {line_tag, cpu_index, {`OFFSET_WID{1'b0}}};
    assign fill_cmd    = cpu_we ? mesi_pkg::mem_read_excl : mesi_pkg::mem_read;

    assign hit      = (line_state != mesi_pkg::mesi_invalid) && (line_tag == cpu_tag);
    assign start    = (state == l1_cache_pkg::ps_idle) && cpu_req && !snoop_busy;
    assign mem_done = mem_req && mem_ack;

    // ====================
    // store updates
    // ====================
    always_comb begin
        tag_wr_en = 1'b0;
        // write hit on E or M goes straight in
        if (start && cpu_we && hit && (line_state != mesi_pkg::mesi_shared)) begin
            tag_wr_en = 1'b1;
        end
        if (mem_done && ((state == l1_cache_pkg::ps_fill) ||
                         (state == l1_cache_pkg::ps_upgrade))) begin
            tag_wr_en = 1'b1;
        end
    end

    assign data_wr_en   = tag_wr_en;
    assign data_wr_data = cpu_we ? cpu_wdata : mem_rdata;
    assign tag_wr_state = cpu_we     ? mesi_pkg::mesi_modified :
                          mem_shared ? mesi_pkg::mesi_shared : mesi_pkg::mesi_exclusive;

    assign proc_busy = (state != l1_cache_pkg::ps_idle) || cpu_req;

    // ====================
    // FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= l1_cache_pkg::ps_idle;
            cpu_ack <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            case (state)
                l1_cache_pkg::ps_idle: begin
                    if (start) begin
                        if (hit && (!cpu_we || line_state != mesi_pkg::mesi_shared)) begin
                            cpu_rdata <= line_data;
                            cpu_ack   <= 1'b1;
                            state     <= l1_cache_pkg::ps_release;
                        end else if (hit) begin
                            mem_req  <= 1'b1;
                            mem_cmd  <= mesi_pkg::mem_upgrade;
                            mem_addr <= line_addr;
                            state    <= l1_cache_pkg::ps_upgrade;
                        end else if (line_state == mesi_pkg::mesi_modified) begin
                            // dirty victim goes out first
                            mem_req   <= 1'b1;
                            mem_cmd   <= mesi_pkg::mem_writeback;
                            mem_addr  <= victim_addr;
                            mem_wdata <= line_data;
                            state     <= l1_cache_pkg::ps_writeback;
                        end else begin
                            mem_req  <= 1'b1;
                            mem_cmd  <= fill_cmd;
                            mem_addr <= line_addr;
                            state    <= l1_cache_pkg::ps_fill;
                        end
                    end
                end
                l1_cache_pkg::ps_writeback: begin
                    if (mem_done) begin
                        mem_req <= 1'b0;
                    end else if (!mem_req && !mem_ack) begin
                        mem_req  <= 1'b1;
                        mem_cmd  <= fill_cmd;
                        mem_addr <= line_addr;
                        state    <= l1_cache_pkg::ps_fill;
                    end
                end
                l1_cache_pkg::ps_fill: begin
                    if (mem_done) begin
                        mem_req   <= 1'b0;
                        cpu_rdata <= mem_rdata;
                        state     <= l1_cache_pkg::ps_respond;
                    end
                end
                l1_cache_pkg::ps_upgrade: begin
                    if (mem_done) begin
                        mem_req <= 1'b0;
                        state   <= l1_cache_pkg::ps_respond;
                    end
                end
                l1_cache_pkg::ps_respond: begin
                    if (!mem_ack) begin
                        cpu_ack <= 1'b1;
                        state   <= l1_cache_pkg::ps_release;
                    end
                end
                l1_cache_pkg::ps_release: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= l1_cache_pkg::ps_idle;
                    end
                end
                default: begin
                    state <= l1_cache_pkg::ps_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/l1_snoop_ctrl.sv ====
// ====================
// snoop side controller
// downgrade on snoop read, drop on invalidate
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_params.svh"

module l1_snoop_ctrl (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      snp_req,
    input  wire mesi_pkg::snp_cmd_t  snp_cmd,
    input  wire l1_cache_pkg::addr_t snp_addr,
    input  wire l1_cache_pkg::tag_t  line_tag,
    input  wire mesi_pkg::mesi_t     line_state,
    input  wire l1_cache_pkg::data_t line_data,
    input  wire                      proc_busy,
    output logic                     snp_ack,
    output logic                     snp_hit,
    output logic                     snp_dirty,
    output l1_cache_pkg::data_t      snp_data,
    output logic                     tag_wr_en,
    output mesi_pkg::mesi_t          tag_wr_state,
    output logic                     snoop_busy
);

    typedef enum logic {
        sn_idle = 1'b0,
        sn_hold = 1'b1
    } snoop_state_t;

    snoop_state_t state;
    logic         accept;
    logic         hit;

    assign accept = (state == sn_idle) && snp_req && !proc_busy;
    assign hit    = (line_state != mesi_pkg::mesi_invalid) &&
                    (line_tag == snp_addr[`ADDR_WID-1 -: `TAG_WID]);

    // state update lands on the accept edge
    assign tag_wr_en    = accept && hit;
    assign tag_wr_state = (snp_cmd == mesi_pkg::snoop_read) ? mesi_pkg::mesi_shared :
                                                              mesi_pkg::mesi_invalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= sn_idle;
        end else if (accept) begin
            state <= sn_hold;
        end else if ((state == sn_hold) && !snp_req) begin
            state <= sn_idle;
        end
    end

    // reply captured before the line changes
    always_ff @(posedge clk) begin
        if (accept) begin
            snp_hit   <= hit;
            snp_dirty <= hit && (line_state == mesi_pkg::mesi_modified);
            snp_data  <= line_data;
        end
    end

    assign snp_ack    = (state == sn_hold);
    assign snoop_busy = (state == sn_hold);

endmodule

`default_nettype wire

// ==== source/l1_dcache.sv ====
// ====================
// l1 data cache top
// tag/data stores, processor and snoop controllers
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_params.svh"

module l1_dcache (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cpu_req,
    input  wire                      cpu_we,
    input  wire l1_cache_pkg::addr_t cpu_addr,
    input  wire l1_cache_pkg::data_t cpu_wdata,
    output logic                     cpu_ack,
    output l1_cache_pkg::data_t      cpu_rdata,
    output logic                     mem_req,
    output mesi_pkg::mem_cmd_t       mem_cmd,
    output l1_cache_pkg::addr_t      mem_addr,
    output l1_cache_pkg::data_t      mem_wdata,
    input  wire                      mem_ack,
    input  wire l1_cache_pkg::data_t mem_rdata,
    input  wire                      mem_shared,
    input  wire                      snp_req,
    input  wire mesi_pkg::snp_cmd_t  snp_cmd,
    input  wire l1_cache_pkg::addr_t snp_addr,
    output logic                     snp_ack,
    output logic                     snp_hit,
    output logic                     snp_dirty,
    output l1_cache_pkg::data_t      snp_data
);

    l1_cache_pkg::index_t proc_index;
    l1_cache_pkg::index_t snoop_index;
    l1_cache_pkg::tag_t   proc_tag;
    l1_cache_pkg::tag_t   snoop_tag;
    mesi_pkg::mesi_t      proc_state;
    mesi_pkg::mesi_t      snoop_state;
    l1_cache_pkg::data_t  proc_data;
    l1_cache_pkg::data_t  snoop_data;
    logic                 proc_tag_wr_en;
    logic                 snoop_tag_wr_en;
    mesi_pkg::mesi_t      proc_tag_wr_state;
    mesi_pkg::mesi_t      snoop_tag_wr_state;
    logic                 data_wr_en;
    l1_cache_pkg::data_t  data_wr_data;
    logic                 proc_busy;
    logic                 snoop_busy;
    logic                 wr_en;
    l1_cache_pkg::index_t wr_index;
    l1_cache_pkg::tag_t   wr_tag;
    mesi_pkg::mesi_t      wr_state;

    assign proc_index  = cpu_addr[`OFFSET_WID +: `INDEX_WID];
    assign snoop_index = snp_addr[`OFFSET_WID +: `INDEX_WID];

    // ====================
    // tag write steering
    // ====================
    // busy handshake keeps the two enables apart
    assign wr_en    = proc_tag_wr_en || snoop_tag_wr_en;
    assign wr_index = snoop_tag_wr_en ? snoop_index : proc_index;
    assign wr_tag   = snoop_tag_wr_en ? snp_addr[`ADDR_WID-1 -: `TAG_WID] :
                                        cpu_addr[`ADDR_WID-1 -: `TAG_WID];
    assign wr_state = snoop_tag_wr_en ? snoop_tag_wr_state : proc_tag_wr_state;

    l1_tag_store i_tag_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .proc_index  (proc_index),
        .snoop_index (snoop_index),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_tag      (wr_tag),
        .wr_state    (wr_state),
        .proc_tag    (proc_tag),
        .proc_state  (proc_state),
        .snoop_tag   (snoop_tag),
        .snoop_state (snoop_state)
    );

    l1_data_store i_data_store (
        .clk         (clk),
        .proc_index  (proc_index),
        .wr_en       (data_wr_en),
        .wr_data     (data_wr_data),
        .snoop_index (snoop_index),
        .proc_data   (proc_data),
        .snoop_data  (snoop_data)
    );

    l1_proc_ctrl i_proc_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .cpu_we       (cpu_we),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .line_tag     (proc_tag),
        .line_state   (proc_state),
        .line_data    (proc_data),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .mem_shared   (mem_shared),
        .snoop_busy   (snoop_busy),
        .cpu_ack      (cpu_ack),
        .cpu_rdata    (cpu_rdata),
        .mem_req      (mem_req),
        .mem_cmd      (mem_cmd),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .tag_wr_en    (proc_tag_wr_en),
        .tag_wr_state (proc_tag_wr_state),
        .data_wr_en   (data_wr_en),
        .data_wr_data (data_wr_data),
        .proc_busy    (proc_busy)
    );

    l1_snoop_ctrl i_snoop_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .snp_req      (snp_req),
        .snp_cmd      (snp_cmd),
        .snp_addr     (snp_addr),
        .line_tag     (snoop_tag),
        .line_state   (snoop_state),
        .line_data    (snoop_data),
        .proc_busy    (proc_busy),
        .snp_ack      (snp_ack),
        .snp_hit      (snp_hit),
        .snp_dirty    (snp_dirty),
        .snp_data     (snp_data),
        .tag_wr_en    (snoop_tag_wr_en),
        .tag_wr_state (snoop_tag_wr_state),
        .snoop_busy   (snoop_busy)
    );

endmodule

`default_nettype wire

// ==== verif/tb_l1_dcache.sv ====
// ====================
// testbench for the l1 data cache
// clock, reset, level 2 model, reference model
// directed and random stimulus, checker, timeout
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_params.svh"

module tb_l1_dcache;

    localparam int N_DIRECTED  = 18;
    localparam int N_RANDOM    = 60;
    localparam int CYCLE_LIMIT = 200 * (N_DIRECTED + N_RANDOM) + 16;

    logic                      clk;
    logic                      rst_n;
    logic                      cpu_req;
    logic                      cpu_we;
    l1_cache_pkg::addr_t       cpu_addr;
    l1_cache_pkg::data_t       cpu_wdata;
    logic                      cpu_ack;
    l1_cache_pkg::data_t       cpu_rdata;
    logic                      mem_req;
    mesi_pkg::mem_cmd_t        mem_cmd;
    l1_cache_pkg::addr_t       mem_addr;
    l1_cache_pkg::data_t       mem_wdata;
    logic                      mem_ack = 1'b0;
    l1_cache_pkg::data_t       mem_rdata = '0;
    logic                      mem_shared = 1'b0;
    logic                      snp_req;
    mesi_pkg::snp_cmd_t        snp_cmd;
    l1_cache_pkg::addr_t       snp_addr;
    logic                      snp_ack;
    logic                      snp_hit;
    logic                      snp_dirty;
    l1_cache_pkg::data_t       snp_data;

    // level 2 model
    l1_cache_pkg::data_t       init_words [64];
    l1_cache_pkg::data_t       l2_mem [64];
    logic                      next_shared;
    int                        l2_cmd_count = 0;

    // reference model
    l1_cache_pkg::data_t       ref_mem [64];
    l1_cache_pkg::tag_t        ref_tag [16];
    mesi_pkg::mesi_t           ref_state [16];
    l1_cache_pkg::data_t       ref_data [16];
    mesi_pkg::mem_cmd_t        exp_cmd [$];
    l1_cache_pkg::addr_t       exp_addr [$];
    l1_cache_pkg::data_t       exp_wdata [$];
    logic                      exp_rd_valid [$];
    l1_cache_pkg::data_t       exp_rd [$];
    logic [33:0]               exp_snp [$];

    logic [31:0]               lfsr;
    string                     test_name;
    int                        check_count = 0;
    int                        error_count = 0;
    int                        cycle_count = 0;
    logic                      cpu_ack_q = 1'b0;
    logic                      mem_req_q = 1'b0;
    logic                      snp_ack_q = 1'b0;

    l1_dcache i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_req    (cpu_req),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_ack    (cpu_ack),
        .cpu_rdata  (cpu_rdata),
        .mem_req    (mem_req),
        .mem_cmd    (mem_cmd),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .mem_shared (mem_shared),
        .snp_req    (snp_req),
        .snp_cmd    (snp_cmd),
        .snp_addr   (snp_addr),
        .snp_ack    (snp_ack),
        .snp_hit    (snp_hit),
        .snp_dirty  (snp_dirty),
        .snp_data   (snp_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // helpers
    // ====================
    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // word number 0..63 to byte address
    function automatic l1_cache_pkg::addr_t word_addr(input logic [5:0] w);
        return {{(`ADDR_WID-8){1'b0}}, w, 2'b00};
    endfunction

    function automatic void expect_cmd(input mesi_pkg::mem_cmd_t cmd,
                                       input l1_cache_pkg::addr_t addr,
                                       input l1_cache_pkg::data_t wdata);
        exp_cmd.push_back(cmd);
        exp_addr.push_back(addr);
        exp_wdata.push_back(wdata);
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (exp === act) else begin
            error_count++;
            $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // ====================
    // reference model
    // ====================
    function automatic l1_cache_pkg::data_t ref_cpu(input logic we,
                                                    input l1_cache_pkg::addr_t addr,
                                                    input l1_cache_pkg::data_t wdata,
                                                    input logic shared);
        l1_cache_pkg::index_t idx;
        l1_cache_pkg::tag_t   tg;
        l1_cache_pkg::addr_t  line;
        l1_cache_pkg::addr_t  victim;
        logic                 hit;
        idx    = addr[`OFFSET_WID +: `INDEX_WID];
        tg     = addr[`ADDR_WID-1 -: `TAG_WID];
        line   = {tg, idx, {`OFFSET_WID{1'b0}}};
        victim = {ref_tag[idx], idx, {`OFFSET_WID{1'b0}}};
        hit    = (ref_state[idx] != mesi_pkg::mesi_invalid) && (ref_tag[idx] == tg);
        if (!hit) begin
            if (ref_state[idx] == mesi_pkg::mesi_modified) begin
                expect_cmd(mesi_pkg::mem_writeback, victim, ref_data[idx]);
                ref_mem[victim[7:2]] = ref_data[idx];
            end
            expect_cmd(we ? mesi_pkg::mem_read_excl : mesi_pkg::mem_read, line, '0);
            ref_tag[idx]   = tg;
            ref_data[idx]  = ref_mem[line[7:2]];
            ref_state[idx] = shared ? mesi_pkg::mesi_shared : mesi_pkg::mesi_exclusive;
        end else if (we && (ref_state[idx] == mesi_pkg::mesi_shared)) begin
            expect_cmd(mesi_pkg::mem_upgrade, line, '0);
        end
        if (we) begin
            ref_data[idx]  = wdata;
            ref_state[idx] = mesi_pkg::mesi_modified;
        end
        return ref_data[idx];
    endfunction

    // reply packed as {hit, dirty, data}
    function automatic logic [33:0] ref_snoop(input mesi_pkg::snp_cmd_t cmd,
                                              input l1_cache_pkg::addr_t addr);
        l1_cache_pkg::index_t idx;
        logic                 hit;
        logic [33:0]          reply;
        idx   = addr[`OFFSET_WID +: `INDEX_WID];
        hit   = (ref_state[idx] != mesi_pkg::mesi_invalid) &&
                (ref_tag[idx] == addr[`ADDR_WID-1 -: `TAG_WID]);
        reply = {hit, hit && (ref_state[idx] == mesi_pkg::mesi_modified), ref_data[idx]};
        if (hit) begin
            ref_state[idx] = (cmd == mesi_pkg::snoop_read) ? mesi_pkg::mesi_shared :
                                                             mesi_pkg::mesi_invalid;
        end
        return reply;
    endfunction

    // ====================
    // level 2 model
    // ====================
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_ack    <= 1'b0;
            mem_shared <= 1'b0;
            for (int i = 0; i < 64; i++) begin
                l2_mem[i] <= init_words[i];
            end
        end else if (mem_req && !mem_ack) begin
            l2_cmd_count <= l2_cmd_count + 1;
            mem_ack      <= 1'b1;
            mem_rdata    <= l2_mem[mem_addr[7:2]];
            mem_shared   <= (mem_cmd == mesi_pkg::mem_read) && next_shared;
            if (mem_cmd == mesi_pkg::mem_writeback) begin
                l2_mem[mem_addr[7:2]] <= mem_wdata;
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack <= 1'b0;
        end
    end

    // ====================
    // checker
    // ====================
    always @(posedge clk) begin : compare
        logic                rd_valid;
        l1_cache_pkg::data_t rd_data;
        mesi_pkg::mem_cmd_t  cmd;
        l1_cache_pkg::data_t wdata;
        logic [33:0]         snp_exp;
        cpu_ack_q <= cpu_ack;
        mem_req_q <= mem_req;
        snp_ack_q <= snp_ack;
        if (cpu_ack && !cpu_ack_q) begin
            rd_valid = exp_rd_valid.pop_front();
            rd_data  = exp_rd.pop_front();
            if (rd_valid) begin
                check_value("cpu_rdata", rd_data, cpu_rdata);
            end
        end
        if (mem_req && !mem_req_q) begin
            check_count++;
            assert (exp_cmd.size() != 0) else begin
                error_count++;
                $display("%s: level-2 command %0d issued while none was expected",
                         test_name, mem_cmd);
            end
            if (exp_cmd.size() != 0) begin
                cmd   = exp_cmd.pop_front();
                wdata = exp_wdata.pop_front();
                check_value("mem_cmd", 32'(cmd), 32'(mem_cmd));
                check_value("mem_addr", exp_addr.pop_front(), mem_addr);
                if (cmd == mesi_pkg::mem_writeback) begin
                    check_value("mem_wdata", wdata, mem_wdata);
                end
            end
        end
        if (snp_ack && !snp_ack_q) begin
            snp_exp = exp_snp.pop_front();
            check_value("snp_hit", 32'(snp_exp[33]), 32'(snp_hit));
            check_value("snp_dirty", 32'(snp_exp[32]), 32'(snp_dirty));
            if (snp_exp[32]) begin
                check_value("snp_data", snp_exp[31:0], snp_data);
            end
        end
    end

    // ====================
    // stimulus tasks
    // ====================
    task automatic cpu_access(input logic we, input l1_cache_pkg::addr_t addr,
                              input l1_cache_pkg::data_t wdata);
        l1_cache_pkg::data_t exp;
        exp = ref_cpu(we, addr, wdata, next_shared);
        exp_rd_valid.push_back(!we);
        exp_rd.push_back(exp);
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_we    <= we;
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        do @(posedge clk); while (!cpu_ack);
        cpu_req <= 1'b0;
        do @(posedge clk); while (cpu_ack);
        // every predicted level 2 command should have been seen
        check_count++;
        assert (exp_cmd.size() == 0) else begin
            error_count++;
            $display("%s: %0d expected level-2 command(s) never issued",
                     test_name, exp_cmd.size());
            exp_cmd.delete();
            exp_addr.delete();
            exp_wdata.delete();
        end
    endtask

    task automatic snoop_access(input mesi_pkg::snp_cmd_t cmd, input l1_cache_pkg::addr_t addr);
        exp_snp.push_back(ref_snoop(cmd, addr));
        @(posedge clk);
        snp_req  <= 1'b1;
        snp_cmd  <= cmd;
        snp_addr <= addr;
        do @(posedge clk); while (!snp_ack);
        snp_req <= 1'b0;
        do @(posedge clk); while (snp_ack);
    endtask

    // ====================
    // test sequence
    // ====================
    initial begin
        logic [1:0]          op;
        l1_cache_pkg::addr_t addr;
        l1_cache_pkg::data_t data;
        cpu_req     = 1'b0;
        cpu_we      = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        snp_req     = 1'b0;
        snp_cmd     = mesi_pkg::snoop_read;
        snp_addr    = '0;
        next_shared = 1'b0;
        rst_n       = 1'b0;
        test_name   = "reset";
        lfsr        = 32'hbb6a_cd52;
        for (int i = 0; i < 64; i++) begin
            init_words[i] = lfsr_bits(32);
            ref_mem[i]    = init_words[i];
        end
        for (int i = 0; i < 16; i++) begin
            ref_state[i] = mesi_pkg::mesi_invalid;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_name = "read_miss_hit";
        cpu_access(1'b0, word_addr(6'd1), '0);
        cpu_access(1'b0, word_addr(6'd1), '0);

        test_name = "write_exclusive";
        cpu_access(1'b1, word_addr(6'd1), 32'h1111_aaaa);
        cpu_access(1'b0, word_addr(6'd1), '0);

        test_name = "write_shared_upgrade";
        next_shared = 1'b1;
        cpu_access(1'b0, word_addr(6'd2), '0);
        cpu_access(1'b1, word_addr(6'd2), 32'h2222_bbbb);
        cpu_access(1'b0, word_addr(6'd2), '0);
        next_shared = 1'b0;

        // word 19 shares index 3 with word 3
        test_name = "write_miss_evict";
        cpu_access(1'b1, word_addr(6'd3), 32'h3333_cccc);
        cpu_access(1'b0, word_addr(6'd19), '0);
        cpu_access(1'b0, word_addr(6'd3), '0);

        test_name = "snoop_read_dirty";
        cpu_access(1'b1, word_addr(6'd4), 32'h4444_dddd);
        snoop_access(mesi_pkg::snoop_read, word_addr(6'd4));
        cpu_access(1'b1, word_addr(6'd4), 32'h4444_eeee);

        test_name = "snoop_inval";
        cpu_access(1'b0, word_addr(6'd5), '0);
        snoop_access(mesi_pkg::snoop_inval, word_addr(6'd5));
        cpu_access(1'b0, word_addr(6'd5), '0);
        snoop_access(mesi_pkg::snoop_read, word_addr(6'd37));
        snoop_access(mesi_pkg::snoop_read, word_addr(6'd6));

        test_name = "random";
        repeat (N_RANDOM) begin
            op          = 2'(lfsr_bits(2));
            addr        = word_addr(6'(lfsr_bits(6)));
            data        = lfsr_bits(32);
            next_shared = 1'(lfsr_bits(1));
            case (op)
                2'd0: cpu_access(1'b0, addr, data);
                2'd1: cpu_access(1'b1, addr, data);
                2'd2: snoop_access(mesi_pkg::snoop_read, addr);
                default: snoop_access(mesi_pkg::snoop_inval, addr);
            endcase
        end

        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d, level-2 commands %0d",
                 check_count, error_count, l2_cmd_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout in %s: run did not finish within %0d cycles",
                     test_name, CYCLE_LIMIT);
            $display("checks %0d, errors %0d, level-2 commands %0d",
                     check_count, error_count, l2_cmd_count);
            $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/mesi_pkg.sv
source/l1_cache_pkg.sv
source/l1_tag_store.sv
source/l1_data_store.sv
source/l1_proc_ctrl.sv
source/l1_snoop_ctrl.sv
source/l1_dcache.sv
verif/tb_l1_dcache.sv

// ==== Bender.yml ====
package:
  name: l1_dcache

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mesi_pkg.sv
      - source/l1_cache_pkg.sv
      - source/l1_tag_store.sv
      - source/l1_data_store.sv
      - source/l1_proc_ctrl.sv
      - source/l1_snoop_ctrl.sv
      - source/l1_dcache.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_l1_dcache.sv
